// ==== flist.f ====
+incdir+src
src/huff_pkg.sv
src/huff_tree_walker.sv
src/huff_header_writer.sv
src/huff_bit_packer.sv
src/huff_header_top.sv
verif/huff_header_assertions.sv
verif/huff_header_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= huff_header_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/huff_header_tb.sv ====
`include "huff_params.svh"

module huff_header_tb;
    import huff_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int N_TREES       = 9;
    localparam int COLLECT_LIMIT = 400;                               // cycles from start to the last byte
    localparam int RUN_CYCLES    = 2 * `HUFF_NODES + COLLECT_LIMIT + 8; // load, walk and settle
    localparam int WATCHDOG_TIME = (RESET_CYCLES + N_TREES * RUN_CYCLES + 100) * CLK_PERIOD;

    logic                    clk;
    logic                    rst;
    logic                    node_we;
    logic [`HUFF_ADDR_W-1:0] node_addr;
    huff_node_t              node_data;
    logic                    start;
    logic                    byte_valid;
    huff_byte_t              out_byte;
    logic                    busy;

    huff_node_t tree_nodes   [N_TREES][`HUFF_NODES]; // node words of each tree
    int         tree_size    [N_TREES];              // nodes to load
    int         tree_bits    [N_TREES];              // expected header length in bits
    bit         tree_restart [N_TREES];              // pulse start again in the middle of the walk
    logic [7:0] exp_bytes    [$];
    integer     seed;
    int         mismatch_errors;
    int         other_errors;

    huff_header_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .node_we    (node_we),
        .node_addr  (node_addr),
        .node_data  (node_data),
        .start      (start),
        .byte_valid (byte_valid),
        .out_byte   (out_byte),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at %0t, the run did not finish in time", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic huff_node_t inner_node(input int left, input int right);
        huff_node_t n;
        n.is_leaf          = 1'b0;
        n.body.inner.left  = 8'(left);
        n.body.inner.right = 8'(right);
        return n;
    endfunction

    function automatic huff_node_t leaf_node(input logic [7:0] c);
        huff_node_t n;
        n.is_leaf              = 1'b1;
        n.body.leaf.spare      = 8'h00;
        n.body.leaf.char_index = c;
        return n;
    endfunction

    task automatic leaf_char(input int t, input int a, input bit rnd, output logic [7:0] c);
        if (rnd) begin
            c = 8'($random(seed));
        end else begin
            c = 8'(t * 37 + a * 11 + 5); // fixed pattern, differs per tree and node
        end
    endtask

    // complete tree of 2**levels leaves in heap order, children of a sit at 2a+1 and 2a+2
    task automatic build_complete(input int t, input int levels, input bit rnd,
                                  input bit restart, input int bits);
        int         n_nodes;
        int         n_inner;
        logic [7:0] c;
        n_nodes = (2 << levels) - 1;
        n_inner = (1 << levels) - 1;
        for (int a = 0; a < n_nodes; a++) begin
            if (a < n_inner) begin
                tree_nodes[t][a] = inner_node(2 * a + 1, 2 * a + 2);
            end else begin
                leaf_char(t, a, rnd, c);
                tree_nodes[t][a] = leaf_node(c);
            end
        end
        tree_size[t]    = n_nodes;
        tree_bits[t]    = bits;
        tree_restart[t] = restart;
    endtask

    // every internal node has a leaf on its left, so the stack never holds more than one entry
    task automatic build_right_skew(input int t, input int m, input bit rnd, input int bits);
        logic [7:0] c;
        for (int k = 0; k < m; k++) begin
            tree_nodes[t][2 * k] = inner_node(2 * k + 1, 2 * k + 2);
            leaf_char(t, 2 * k + 1, rnd, c);
            tree_nodes[t][2 * k + 1] = leaf_node(c);
        end
        leaf_char(t, 2 * m, rnd, c);
        tree_nodes[t][2 * m] = leaf_node(c);
        tree_size[t]    = 2 * m + 1;
        tree_bits[t]    = bits;
        tree_restart[t] = 1'b0;
    endtask

    // left spine of m internal nodes at 0..m-1, each pushes its right leaf before descending
    task automatic build_left_skew(input int t, input int m, input bit rnd, input int bits);
        logic [7:0] c;
        for (int k = 0; k < m; k++) begin
            tree_nodes[t][k] = inner_node((k < m - 1) ? k + 1 : m, m + 1 + k);
        end
        for (int a = m; a <= 2 * m; a++) begin
            leaf_char(t, a, rnd, c);
            tree_nodes[t][a] = leaf_node(c);
        end
        tree_size[t]    = 2 * m + 1;
        tree_bits[t]    = bits;
        tree_restart[t] = 1'b0;
    endtask

    task automatic build_table();
        build_complete(0, 0, 1'b0, 1'b0, 9);    // single leaf
        build_complete(1, 2, 1'b0, 1'b0, 39);   // balanced, four leaves
        build_left_skew(2, 15, 1'b0, 159);      // deepest spine that fits the node memory
        build_right_skew(3, 8, 1'b0, 89);
        build_complete(4, 2, 1'b0, 1'b1, 39);   // second start while busy
        build_complete(5, 3, 1'b1, 1'b0, 79);
        build_right_skew(6, 5, 1'b1, 59);
        build_complete(7, 0, 1'b1, 1'b0, 9);
        build_complete(8, 4, 1'b1, 1'b1, 159);
    endtask

    // preorder walk, 0 for an internal node, 1 and the char msb first for a leaf
    task automatic model_header(input int t);
        int         pending [$];
        bit         bits [$];
        int         a;
        huff_node_t n;
        logic [7:0] b;
        exp_bytes.delete();
        pending.push_back(0);
        while (pending.size() > 0) begin
            a = pending.pop_back();
            n = tree_nodes[t][a];
            if (n.is_leaf) begin
                bits.push_back(1'b1);
                for (int i = 7; i >= 0; i--) begin
                    bits.push_back(n.body.leaf.char_index[i]);
                end
            end else begin
                bits.push_back(1'b0);
                pending.push_back(int'(n.body.inner.right)); // popped after the whole left subtree
                pending.push_back(int'(n.body.inner.left));
            end
        end
        for (int i = 0; i < bits.size(); i += 8) begin
            b = 8'h00;
            for (int j = 0; j < 8; j++) begin
                b = {b[6:0], (i + j < bits.size()) ? bits[i + j] : 1'b0};
            end
            exp_bytes.push_back(b);
        end
    endtask

    task automatic check_byte(input int t, input int idx);
        logic exp_last;
        assert (idx < exp_bytes.size()) else begin
            other_errors++;
            $display("tree %0d sent more bytes than its header holds at %0t", t, $time);
        end
        if (idx < exp_bytes.size()) begin
            exp_last = (idx == exp_bytes.size() - 1);
            assert (out_byte.data == exp_bytes[idx]) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: out_byte.data (tree %0d byte %0d) got %02h expected %02h",
                         $time, t, idx, out_byte.data, exp_bytes[idx]);
            end
            assert (out_byte.last == exp_last) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: out_byte.last (tree %0d byte %0d) got %0b expected %0b",
                         $time, t, idx, out_byte.last, exp_last);
            end
        end
    endtask

    task automatic run_tree(input int t);
        int n_got;
        int cycles;
        int exp_n;
        bit got_last;
        model_header(t);
        exp_n = (tree_bits[t] + 7) / 8;
        for (int a = 0; a < tree_size[t]; a++) begin
            @(posedge clk);
            #1;
            node_we   = 1'b1;
            node_addr = `HUFF_ADDR_W'(a);
            node_data = tree_nodes[t][a];
        end
        @(posedge clk);
        #1;
        node_we = 1'b0;
        start   = 1'b1;
        @(posedge clk);
        #1;
        start    = 1'b0;
        n_got    = 0;
        cycles   = 0;
        got_last = 1'b0;
        while (!got_last && cycles < COLLECT_LIMIT) begin
            @(posedge clk);
            #1;
            start = tree_restart[t] && (cycles == 5);
            @(negedge clk);
            cycles++;
            if (byte_valid) begin
                check_byte(t, n_got);
                got_last = out_byte.last;
                n_got++;
            end
        end
        assert (got_last) else begin
            other_errors++;
            $display("tree %0d: no byte with last set within %0d cycles", t, COLLECT_LIMIT);
        end
        assert (!busy) else begin
            other_errors++;
            $display("tree %0d: busy stayed high after the header ended", t);
        end
        assert (n_got == exp_n) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: byte count (tree %0d) got %0d expected %0d",
                     $time, t, n_got, exp_n);
        end
        repeat (4) begin
            @(negedge clk);
            assert (!byte_valid) else begin
                other_errors++;
                $display("tree %0d: a byte came out after the last one at %0t", t, $time);
            end
        end
    endtask

    initial begin
        rst             = 1'b1;
        node_we         = 1'b0;
        node_addr       = '0;
        node_data       = '0;
        start           = 1'b0;
        seed            = 32'h61b5_0d86;
        mismatch_errors = 0;
        other_errors    = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int t = 0; t < N_TREES; t++) begin
            run_tree(t); // trees follow each other with no reset in between
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verif/huff_header_assertions.sv ====
module huff_header_assertions (
    input logic clk,
    input logic rst,
    input logic ev_valid,
    input logic ev_done,
    input logic bit_valid,
    input logic byte_valid
);
    logic ev_pending; // writer has taken an event and not yet sent its last bit

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ev_pending <= 1'b0;
        end else if (ev_valid) begin
            ev_pending <= 1'b1;
        end else if (ev_done) begin
            ev_pending <= 1'b0;
        end
    end

    a_done_needs_event: assert property (@(posedge clk) disable iff (rst)
        ev_done |-> ev_pending)
        else $error("ev_done without an outstanding event");

    a_event_while_writing: assert property (@(posedge clk) disable iff (rst)
        ev_valid |-> !ev_pending)
        else $error("ev_valid while the writer still shifts the previous event");

    a_byte_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !byte_valid)
        else $error("byte_valid high right after reset");

    a_bit_apart_from_event: assert property (@(posedge clk) disable iff (rst)
        !(bit_valid && ev_valid))
        else $error("bit_valid and ev_valid high in the same cycle");

endmodule

bind huff_header_top huff_header_assertions i_assertions (
    .clk        (clk),
    .rst        (rst),
    .ev_valid   (ev_valid),
    .ev_done    (ev_done),
    .bit_valid  (bit_valid),
    .byte_valid (byte_valid)
);

// ==== src/huff_header_top.sv ====
`include "huff_params.svh"

module huff_header_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    node_we,
    input  logic [`HUFF_ADDR_W-1:0] node_addr,
    input  huff_pkg::huff_node_t    node_data,
    input  logic                    start,
    output logic                    byte_valid,
    output huff_pkg::huff_byte_t    out_byte,
    output logic                    busy
);
    import huff_pkg::*;

    logic        ev_valid;  // walker has a node for the writer
    huff_event_t ev;
    logic        ev_done;   // writer has sent the event's last bit
    logic        bit_valid;
    logic        bit_value;
    logic        flush;     // end of header, from the walker

    huff_tree_walker i_walker (
        .clk       (clk),
        .rst       (rst),
        .node_we   (node_we),
        .node_addr (node_addr),
        .node_data (node_data),
        .start     (start),
        .ev_done   (ev_done),
        .ev_valid  (ev_valid),
        .ev        (ev),
        .flush     (flush),
        .busy      (busy)
    );

    huff_header_writer i_writer (
        .clk       (clk),
        .rst       (rst),
        .ev_valid  (ev_valid),
        .ev        (ev),
        .ev_done   (ev_done),
        .bit_valid (bit_valid),
        .bit_value (bit_value)
    );

    huff_bit_packer i_packer (
        .clk        (clk),
        .rst        (rst),
        .bit_valid  (bit_valid),
        .bit_value  (bit_value),
        .flush      (flush),
        .byte_valid (byte_valid),
        .out_byte   (out_byte)
    );

endmodule

// ==== src/huff_bit_packer.sv ====
module huff_bit_packer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 bit_valid,
    input  logic                 bit_value,
    input  logic                 flush,
    output logic                 byte_valid,
    output huff_pkg::huff_byte_t out_byte
);
    logic [7:0] acc;        // incoming bits enter at the lsb
    logic [2:0] fill;       // bits collected in acc so far
    logic [7:0] hold_data;  // finished byte waiting to leave
    logic       hold_valid;
    logic       hold_last;
    logic       byte_full;
    logic       pad_out;
    logic [7:0] padded;

    assign byte_full = bit_valid && (fill == 3'd7);
    assign pad_out   = flush && (fill != 3'd0);
    assign padded    = acc << (4'd8 - {1'b0, fill}); // zeros fill the low bits

    always_ff @(posedge clk) begin
        if (bit_valid) begin
            acc <= {acc[6:0], bit_value};
        end
        if (byte_full) begin
            hold_data <= {acc[6:0], bit_value};
        end else if (pad_out) begin
            hold_data <= padded;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            fill       <= '0;
            hold_valid <= 1'b0;
            hold_last  <= 1'b0;
        end else begin
            if (flush) begin
                fill <= '0;
            end else if (bit_valid) begin
                fill <= fill + 1'b1; // wraps to zero on the eighth bit
            end
            hold_valid <= byte_full || pad_out;
            hold_last  <= pad_out;
        end
    end

    // a full byte leaves the cycle after its eighth bit, flush lands in that same cycle
    // when the header ends exactly on a byte boundary
    assign byte_valid    = hold_valid;
    assign out_byte.data = hold_data;
    assign out_byte.last = hold_last || (hold_valid && flush);

endmodule

// ==== src/huff_header_writer.sv ====
module huff_header_writer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ev_valid,
    input  huff_pkg::huff_event_t ev,
    output logic                  ev_done,
    output logic                  bit_valid,
    output logic                  bit_value
);
    localparam logic [3:0] LEAF_BITS  = 4'd9; // control 1 plus the character index
    localparam logic [3:0] INNER_BITS = 4'd1; // a single 0

    logic [8:0] shreg;
    logic [8:0] next_shreg;
    logic [3:0] bits_left;
    logic [3:0] next_bits_left;
    logic       active;
    logic       next_active;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bits_left <= '0;
            active    <= 1'b0;
        end else begin
            bits_left <= next_bits_left;
            active    <= next_active;
        end
    end

    always_ff @(posedge clk) begin
        shreg <= next_shreg;
    end

    always_comb begin
        next_shreg     = shreg;
        next_bits_left = bits_left;
        next_active    = active;

        if (ev_valid) begin
            // a new event never arrives while a previous one is still going out
            if (ev.is_leaf) begin
                next_shreg     = {1'b1, ev.char_index};
                next_bits_left = LEAF_BITS;
            end else begin
                next_shreg     = 9'b0;          // internal node, the msb is the only bit used
                next_bits_left = INNER_BITS;
            end
            next_active = 1'b1;
        end else if (active) begin
            next_shreg     = {shreg[7:0], 1'b0}; // msb has just gone out
            next_bits_left = bits_left - 1'b1;
            if (bits_left == 4'd1) begin
                next_active = 1'b0;
            end
        end
    end

    // every active cycle carries one bit, the finish strobe rides on the final one
    assign bit_valid = active;
    assign bit_value = shreg[8];
    assign ev_done   = active && (bits_left == 4'd1);

endmodule

// ==== src/huff_tree_walker.sv ====
`include "huff_params.svh"

module huff_tree_walker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      node_we,
    input  logic [`HUFF_ADDR_W-1:0]   node_addr,
    input  huff_pkg::huff_node_t      node_data,
    input  logic                      start,
    input  logic                      ev_done,
    output logic                      ev_valid,
    output huff_pkg::huff_event_t     ev,
    output logic                      flush,
    output logic                      busy
);
    import huff_pkg::*;

    localparam int SP_W = $clog2(`HUFF_STACK_DEPTH) + 1; // one extra bit to count a full stack

    typedef enum logic [1:0] {
        S_IDLE,  // waiting for start
        S_ISSUE, // event goes out, next address is chosen
        S_WAIT   // writer is still shifting the event out
    } walk_state_t;

    walk_state_t              state;
    huff_node_t               node_mem [`HUFF_NODES];
    logic [`HUFF_ADDR_W-1:0]  stack_mem [`HUFF_STACK_DEPTH];
    logic [`HUFF_ADDR_W-1:0]  cur_addr;
    logic [SP_W-1:0]          sp;
    logic [SP_W-1:0]          sp_top;
    logic                     walk_end;
    huff_node_t               cur_node;
    logic                     stack_empty;

    // tree loading, only done by the host while the walker is idle
    always_ff @(posedge clk) begin
        if (node_we) begin
            node_mem[node_addr] <= node_data;
        end
    end

    assign cur_node    = node_mem[cur_addr];
    assign sp_top      = sp - 1'b1;       // index of the most recent push
    assign stack_empty = (sp == '0);

    // right subtree is remembered while the left one is walked
    always_ff @(posedge clk) begin
        if (state == S_ISSUE && !cur_node.is_leaf) begin
            stack_mem[sp[SP_W-2:0]] <= cur_node.body.inner.right[`HUFF_ADDR_W-1:0];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            cur_addr <= '0;
            sp       <= '0;
            walk_end <= 1'b0;
            flush    <= 1'b0;
        end else begin
            flush <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_ISSUE;
                        cur_addr <= '0;         // the root always sits at address 0
                        sp       <= '0;
                        walk_end <= 1'b0;
                    end
                end
                S_ISSUE: begin
                    state <= S_WAIT;
                    if (!cur_node.is_leaf) begin
                        sp       <= sp + 1'b1;  // preorder goes left first
                        cur_addr <= cur_node.body.inner.left[`HUFF_ADDR_W-1:0];
                    end else if (!stack_empty) begin
                        sp       <= sp_top;     // resume at the nearest pending right child
                        cur_addr <= stack_mem[sp_top[SP_W-2:0]];
                    end else begin
                        walk_end <= 1'b1;       // leaf with nothing pending closes the tree
                    end
                end
                S_WAIT: begin
                    if (ev_done) begin
                        if (walk_end) begin
                            state <= S_IDLE;
                            flush <= 1'b1;      // tells the packer the header is complete
                        end else begin
                            state <= S_ISSUE;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // event contents follow the node under the cursor
    always_comb begin
        ev.is_leaf    = cur_node.is_leaf;
        ev.char_index = cur_node.is_leaf ? cur_node.body.leaf.char_index : 8'h00;
    end

    assign ev_valid = (state == S_ISSUE);
    assign busy     = (state != S_IDLE);

endmodule

// ==== src/huff_pkg.sv ====
package huff_pkg;

    // child addresses of an internal node, widened to a full byte each
    typedef struct packed {
        logic [7:0] left;  // address of the left child
        logic [7:0] right; // address of the right child
    } huff_inner_t;

    // payload of a leaf node
    typedef struct packed {
        logic [7:0] spare;      // unused, keeps the view 16 bits wide
        logic [7:0] char_index; // character carried by the leaf
    } huff_leaf_t;

    // one 16-bit body, read as child pointers or as a leaf character
    typedef union packed {
        huff_inner_t inner;
        huff_leaf_t  leaf;
    } huff_node_body_u;

    // node memory word, is_leaf picks the view of the body
    typedef struct packed {
        logic            is_leaf;
        huff_node_body_u body;
    } huff_node_t;

    // one header event from the walker to the writer
    typedef struct packed {
        logic       is_leaf;    // 1 gives nine bits, 0 gives a single bit
        logic [7:0] char_index; // only meaningful for a leaf
    } huff_event_t;

    // one packed output byte
    typedef struct packed {
        logic [7:0] data; // header bits, first bit in the msb
        logic       last; // set on the final byte of the header
    } huff_byte_t;

endpackage

// ==== src/huff_params.svh ====
`ifndef HUFF_PARAMS_SVH
`define HUFF_PARAMS_SVH

// entries in the node memory
`define HUFF_NODES 32

// width of a node address, enough to reach every entry
`define HUFF_ADDR_W 5

// entries in the traversal stack
// this bounds how many internal nodes a single root-to-leaf path may hold
`define HUFF_STACK_DEPTH 16

`endif
